/* logic/regf_pkg.sv */
// ---------------------------
// Register file read path definitions
// Sizes and arbitration periods
// Element ids, read request and side information
// ---------------------------
package regf_pkg;

  // ---------------------------
  // Geometry
  // ---------------------------
  localparam int REGF_REG_NB          = 16;
  localparam int REGF_REGID_W         = 4;
  // Offset REGF_WORD_PER_RAM itself selects the body word
  localparam int REGF_WORD_PER_RAM    = 4;
  localparam int REGF_BLWE_WORD_CNT_W = 3;
  localparam int REGF_RAM_WORD_ADD_W  = 6;
  localparam int REGF_MASK_RAM_DEPTH  = REGF_REG_NB * REGF_WORD_PER_RAM;
  localparam int REGF_DATA_W          = 16;

  // ---------------------------
  // Arbitration
  // ---------------------------
  localparam int PE_NB = 3;

  // Minimum cycles between two selections of one element
  localparam int PEA_PERIOD = 4;
  localparam int PEM_PERIOD = 4;
  localparam int PEP_PERIOD = 1;

  // Counter holds period minus one
  localparam int PE_PERIOD_CNT_W = 2;
  localparam int PE_PERIOD [PE_NB] = '{PEA_PERIOD, PEM_PERIOD, PEP_PERIOD};

  // ---------------------------
  // Types
  // ---------------------------
  typedef logic [REGF_REGID_W-1:0]         reg_id_t;
  typedef logic [REGF_BLWE_WORD_CNT_W-1:0] word_cnt_t;
  typedef logic [REGF_RAM_WORD_ADD_W-1:0]  mask_add_t;
  typedef logic [REGF_DATA_W-1:0]          data_t;
  typedef logic [PE_PERIOD_CNT_W-1:0]      period_cnt_t;

  // Priority order, ALU highest
  typedef enum logic [1:0] {
    PE_ALU = 2'd0,
    PE_MEM = 2'd1,
    PE_PBS = 2'd2
  } pe_id_e;

  typedef struct packed {
    reg_id_t   reg_id;
    reg_id_t   reg_id_1;
    logic      do_2_read;
    word_cnt_t start_word;
    word_cnt_t word_nb_m1;
  } regf_rd_req_t;

  typedef struct packed {
    pe_id_e pe_id;
    logic   last_mask;
    logic   last_word;
  } regf_side_t;

endpackage

/* logic/regf_ram_rd_if.sv */
// ---------------------------
// Read command from the arbiter to the RAM bank
// One mask or body read per cycle, no back-pressure
// ---------------------------
`timescale 1ns/1ps

interface regf_ram_rd_if;

  logic                  mask_en;
  regf_pkg::mask_add_t   mask_add;
  logic                  body_en;
  regf_pkg::reg_id_t     body_add;
  // Travels with the read down to the output
  regf_pkg::regf_side_t  side;

  modport src (
    output mask_en,
    output mask_add,
    output body_en,
    output body_add,
    output side
  );

  modport dst (
    input mask_en,
    input mask_add,
    input body_en,
    input body_add,
    input side
  );

endinterface

/* logic/regf_req_buffer.sv */
// ---------------------------
// Two-entry valid/ready queue
// Holds one element's read requests
// ---------------------------
`timescale 1ns/1ps

module regf_req_buffer (
  input  logic                   clk,
  input  logic                   s_rst_n,

  input  logic                   in_vld,
  output logic                   in_rdy,
  input  regf_pkg::regf_rd_req_t in_req,

  output logic                   out_vld,
  input  logic                   out_rdy,
  output regf_pkg::regf_rd_req_t out_req
);

  // Entry 0 is the head
  logic                   ent0_vld;
  logic                   ent1_vld;
  regf_pkg::regf_rd_req_t ent0_req;
  regf_pkg::regf_rd_req_t ent1_req;

  logic push;
  logic pop;
  logic ent0_load;

  // Ready shown against a pending request while an entry is free
  assign in_rdy  = in_vld & ~ent1_vld;
  assign out_vld = ent0_vld;
  assign out_req = ent0_req;

  assign push      = in_vld & in_rdy;
  assign pop       = ent0_vld & out_rdy;
  assign ent0_load = pop | ~ent0_vld;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ent0_vld <= 1'b0;
      ent1_vld <= 1'b0;
    end else begin
      if (push && !pop) begin
        if (ent0_vld) begin
          ent1_vld <= 1'b1;
        end else begin
          ent0_vld <= 1'b1;
        end
      end else if (pop && !push) begin
        // Second entry moves up
        ent0_vld <= ent1_vld;
        ent1_vld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ent0_load) begin
      ent0_req <= ent1_vld ? ent1_req : in_req;
    end
    if (push && !ent0_load) begin
      ent1_req <= in_req;
    end
  end

endmodule

/* logic/regf_read_arbiter.sv */
// ---------------------------
// Read arbiter for the three elements
// Period limited fixed priority selection
// Word address build and read command register
// ---------------------------
`timescale 1ns/1ps

module regf_read_arbiter (
  input  logic                                          clk,
  input  logic                                          s_rst_n,

  input  logic [regf_pkg::PE_NB-1:0]                    req_vld,
  output logic [regf_pkg::PE_NB-1:0]                    req_rdy,
  input  regf_pkg::regf_rd_req_t [regf_pkg::PE_NB-1:0]  req,

  regf_ram_rd_if.src                                    rd
);

  // ---------------------------
  // s0 selection
  // ---------------------------
  regf_pkg::period_cnt_t [regf_pkg::PE_NB-1:0] s0_period_cnt;
  regf_pkg::period_cnt_t [regf_pkg::PE_NB-1:0] s0_period_cnt_d;
  regf_pkg::word_cnt_t [regf_pkg::PE_NB-1:0]   s0_word_cnt;
  regf_pkg::word_cnt_t [regf_pkg::PE_NB-1:0]   s0_word_cnt_d;
  // Pending read from reg_id_1
  logic [regf_pkg::PE_NB-1:0]                  s0_second;
  logic [regf_pkg::PE_NB-1:0]                  s0_second_d;

  logic [regf_pkg::PE_NB-1:0] s0_eligible;
  logic [regf_pkg::PE_NB-1:0] s0_sel_first;
  logic [regf_pkg::PE_NB-1:0] s0_sel;
  logic [regf_pkg::PE_NB-1:0] s0_last_word;
  logic [regf_pkg::PE_NB-1:0] s0_inc_word;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_period_cnt <= '0;
      s0_word_cnt   <= '0;
      s0_second     <= '0;
    end else begin
      s0_period_cnt <= s0_period_cnt_d;
      s0_word_cnt   <= s0_word_cnt_d;
      s0_second     <= s0_second_d;
    end
  end

  always_comb begin
    for (int p = 0; p < regf_pkg::PE_NB; p++) begin
      s0_eligible[p] = req_vld[p] & (s0_period_cnt[p] == '0);
    end
  end

  // Lowest id wins, a pending second read takes the whole cycle
  always_comb begin : prio_sel
    logic taken;
    taken = |s0_second;
    for (int p = 0; p < regf_pkg::PE_NB; p++) begin
      s0_sel_first[p] = s0_eligible[p] & ~taken;
      taken           = taken | s0_eligible[p];
    end
  end

  assign s0_sel = s0_sel_first | s0_second;

  always_comb begin
    for (int p = 0; p < regf_pkg::PE_NB; p++) begin
      s0_last_word[p] = (s0_word_cnt[p] == req[p].word_nb_m1);
      // A pair only advances after its reg_id_1 read
      s0_inc_word[p]  = (s0_sel_first[p] & ~req[p].do_2_read) | s0_second[p];
      s0_second_d[p]  = s0_sel_first[p] & req[p].do_2_read;

      if (s0_sel_first[p]) begin
        s0_period_cnt_d[p] = regf_pkg::period_cnt_t'(regf_pkg::PE_PERIOD[p] - 1);
      end else if (s0_period_cnt[p] != '0) begin
        s0_period_cnt_d[p] = s0_period_cnt[p] - 1'b1;
      end else begin
        s0_period_cnt_d[p] = s0_period_cnt[p];
      end

      if (s0_inc_word[p]) begin
        s0_word_cnt_d[p] = s0_last_word[p] ? '0 : s0_word_cnt[p] + 1'b1;
      end else begin
        s0_word_cnt_d[p] = s0_word_cnt[p];
      end

      // Buffer released with the final read
      req_rdy[p] = s0_inc_word[p] & s0_last_word[p];
    end
  end

  // Selected request towards s1
  regf_pkg::regf_rd_req_t s0_sel_req;
  regf_pkg::word_cnt_t    s0_sel_word;
  regf_pkg::pe_id_e       s0_sel_pe;
  logic                   s0_avail;
  logic                   s0_read_2nd;
  logic                   s0_read_last;

  assign s0_avail     = |s0_sel;
  assign s0_read_2nd  = |s0_second;
  assign s0_read_last = |req_rdy;

  always_comb begin
    s0_sel_req  = '0;
    s0_sel_word = '0;
    s0_sel_pe   = regf_pkg::PE_ALU;
    for (int p = 0; p < regf_pkg::PE_NB; p++) begin
      if (s0_sel[p]) begin
        s0_sel_req  = req[p];
        s0_sel_word = s0_word_cnt[p];
        s0_sel_pe   = regf_pkg::pe_id_e'(p);
      end
    end
  end

  // ---------------------------
  // s1 address build
  // ---------------------------
  logic                   s1_avail;
  regf_pkg::regf_rd_req_t s1_req;
  regf_pkg::word_cnt_t    s1_word;
  regf_pkg::pe_id_e       s1_pe;
  logic                   s1_read_2nd;
  logic                   s1_read_last;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s1_avail <= 1'b0;
    end else begin
      s1_avail <= s0_avail;
    end
  end

  always_ff @(posedge clk) begin
    s1_req       <= s0_sel_req;
    s1_word      <= s0_sel_word;
    s1_pe        <= s0_sel_pe;
    s1_read_2nd  <= s0_read_2nd;
    s1_read_last <= s0_read_last;
  end

  regf_pkg::reg_id_t    s1_reg_id;
  regf_pkg::word_cnt_t  s1_word_ofs;
  regf_pkg::mask_add_t  s1_mask_add;
  logic                 s1_is_body;
  regf_pkg::regf_side_t s1_side;

  assign s1_reg_id   = s1_read_2nd ? s1_req.reg_id_1 : s1_req.reg_id;
  assign s1_word_ofs = s1_req.start_word + s1_word;
  assign s1_is_body  = (s1_word_ofs == regf_pkg::REGF_WORD_PER_RAM);
  // Four mask words per register
  assign s1_mask_add = regf_pkg::mask_add_t'(s1_reg_id * regf_pkg::REGF_WORD_PER_RAM
                                             + s1_word_ofs);

  assign s1_side.pe_id     = s1_pe;
  assign s1_side.last_mask = (s1_word_ofs == regf_pkg::REGF_WORD_PER_RAM - 1);
  assign s1_side.last_word = s1_read_last;

  // ---------------------------
  // s2 command register
  // ---------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd.mask_en <= 1'b0;
      rd.body_en <= 1'b0;
    end else begin
      rd.mask_en <= s1_avail & ~s1_is_body;
      rd.body_en <= s1_avail & s1_is_body;
    end
  end

  always_ff @(posedge clk) begin
    rd.mask_add <= s1_mask_add;
    rd.body_add <= s1_reg_id;
    rd.side     <= s1_side;
  end

endmodule

/* logic/regf_ram_bank.sv */
// ---------------------------
// Mask RAM and body RAM
// Write port, registered read, tagged output
// ---------------------------
`timescale 1ns/1ps

module regf_ram_bank (
  input  logic                 clk,
  input  logic                 s_rst_n,

  regf_ram_rd_if.dst           rd,

  input  logic                 wr_en,
  input  logic                 wr_is_body,
  input  regf_pkg::reg_id_t    wr_reg_id,
  input  regf_pkg::word_cnt_t  wr_word,
  input  regf_pkg::data_t      wr_data,

  output logic                 out_vld,
  output regf_pkg::data_t      out_data,
  output regf_pkg::regf_side_t out_side
);

  regf_pkg::data_t     mask_ram [regf_pkg::REGF_MASK_RAM_DEPTH];
  regf_pkg::data_t     body_ram [regf_pkg::REGF_REG_NB];
  regf_pkg::mask_add_t wr_mask_add;

  // ---------------------------
  // Write port
  // ---------------------------
  assign wr_mask_add = regf_pkg::mask_add_t'(wr_reg_id * regf_pkg::REGF_WORD_PER_RAM
                                             + wr_word);

  always_ff @(posedge clk) begin
    if (wr_en && !wr_is_body) begin
      mask_ram[wr_mask_add] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && wr_is_body) begin
      body_ram[wr_reg_id] <= wr_data;
    end
  end

  // ---------------------------
  // Read
  // ---------------------------
  // At most one enable per cycle
  always_ff @(posedge clk) begin
    if (rd.mask_en) begin
      out_data <= mask_ram[rd.mask_add];
    end else if (rd.body_en) begin
      out_data <= body_ram[rd.body_add];
    end
    out_side <= rd.side;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= rd.mask_en | rd.body_en;
    end
  end

endmodule

/* logic/regf_read_top.sv */
// ---------------------------
// Register file read path top
// Three request buffers, arbiter, RAM bank
// ---------------------------
`timescale 1ns/1ps

module regf_read_top (
  input  logic                   clk,
  input  logic                   s_rst_n,

  // ALU requests
  input  logic                   alu_req_vld,
  output logic                   alu_req_rdy,
  input  regf_pkg::regf_rd_req_t alu_req,

  // MEM requests
  input  logic                   mem_req_vld,
  output logic                   mem_req_rdy,
  input  regf_pkg::regf_rd_req_t mem_req,

  // PBS requests
  input  logic                   pbs_req_vld,
  output logic                   pbs_req_rdy,
  input  regf_pkg::regf_rd_req_t pbs_req,

  // Write port
  input  logic                   wr_en,
  input  logic                   wr_is_body,
  input  regf_pkg::reg_id_t      wr_reg_id,
  input  regf_pkg::word_cnt_t    wr_word,
  input  regf_pkg::data_t        wr_data,

  // Read data
  output logic                   out_vld,
  output regf_pkg::data_t        out_data,
  output regf_pkg::pe_id_e       out_pe_id,
  output logic                   out_last_mask,
  output logic                   out_last_word
);

  logic [regf_pkg::PE_NB-1:0]                   buf_vld;
  logic [regf_pkg::PE_NB-1:0]                   buf_rdy;
  regf_pkg::regf_rd_req_t [regf_pkg::PE_NB-1:0] buf_req;
  regf_pkg::regf_side_t                         bank_side;

  regf_ram_rd_if rd_if ();

  // ---------------------------
  // Request buffers
  // ---------------------------
  regf_req_buffer alu_buf (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .in_vld  (alu_req_vld),
    .in_rdy  (alu_req_rdy),
    .in_req  (alu_req),
    .out_vld (buf_vld[regf_pkg::PE_ALU]),
    .out_rdy (buf_rdy[regf_pkg::PE_ALU]),
    .out_req (buf_req[regf_pkg::PE_ALU])
  );

  regf_req_buffer mem_buf (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .in_vld  (mem_req_vld),
    .in_rdy  (mem_req_rdy),
    .in_req  (mem_req),
    .out_vld (buf_vld[regf_pkg::PE_MEM]),
    .out_rdy (buf_rdy[regf_pkg::PE_MEM]),
    .out_req (buf_req[regf_pkg::PE_MEM])
  );

  regf_req_buffer pbs_buf (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .in_vld  (pbs_req_vld),
    .in_rdy  (pbs_req_rdy),
    .in_req  (pbs_req),
    .out_vld (buf_vld[regf_pkg::PE_PBS]),
    .out_rdy (buf_rdy[regf_pkg::PE_PBS]),
    .out_req (buf_req[regf_pkg::PE_PBS])
  );

  // ---------------------------
  // Arbiter and RAMs
  // ---------------------------
  regf_read_arbiter arb (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .req_vld (buf_vld),
    .req_rdy (buf_rdy),
    .req     (buf_req),
    .rd      (rd_if.src)
  );

  regf_ram_bank bank (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .rd         (rd_if.dst),
    .wr_en      (wr_en),
    .wr_is_body (wr_is_body),
    .wr_reg_id  (wr_reg_id),
    .wr_word    (wr_word),
    .wr_data    (wr_data),
    .out_vld    (out_vld),
    .out_data   (out_data),
    .out_side   (bank_side)
  );

  assign out_pe_id     = bank_side.pe_id;
  assign out_last_mask = bank_side.last_mask;
  assign out_last_word = bank_side.last_word;

endmodule

/* bench/regf_read_tb.sv */
// ------------------------------
// Testbench for the register file read path
// Clock, reset, LFSR register load and model arrays
// Expected word queues built from the request rules
// Stimulus table, compare tasks, final report
// ------------------------------
`timescale 1ns/1ps

module regf_read_tb;

  localparam int NUM_ROWS     = 6;
  localparam int ACCEPT_LIMIT = 100;
  localparam int DRAIN_LIMIT  = 500;
  localparam int MIN_GAP      = 4;

  typedef struct packed {
    regf_pkg::data_t      data;
    regf_pkg::regf_side_t side;
    logic                 second;
  } exp_word_t;

  // One stimulus row, element index 0 is ALU
  typedef struct packed {
    logic [2:0]                   pe_mask;
    logic [3:0]                   rep;
    regf_pkg::regf_rd_req_t [2:0] req;
    logic [2:0][5:0]              exp_cnt;
  } row_t;

  logic                   clk;
  logic                   s_rst_n;
  logic                   req_vld [regf_pkg::PE_NB];
  logic                   req_rdy [regf_pkg::PE_NB];
  regf_pkg::regf_rd_req_t req_bus [regf_pkg::PE_NB];
  logic                   wr_en;
  logic                   wr_is_body;
  regf_pkg::reg_id_t      wr_reg_id;
  regf_pkg::word_cnt_t    wr_word;
  regf_pkg::data_t        wr_data;
  logic                   out_vld;
  regf_pkg::data_t        out_data;
  regf_pkg::pe_id_e       out_pe_id;
  logic                   out_last_mask;
  logic                   out_last_word;

  regf_pkg::data_t  mask_model [regf_pkg::REGF_MASK_RAM_DEPTH];
  regf_pkg::data_t  body_model [regf_pkg::REGF_REG_NB];
  exp_word_t        exp_alu [$];
  exp_word_t        exp_mem [$];
  exp_word_t        exp_pbs [$];
  int               recv_cnt [regf_pkg::PE_NB];
  int               last_first_cyc [regf_pkg::PE_NB];
  int               cyc = 0;
  int               mismatch_cnt;
  int               other_err_cnt;
  logic [15:0]      lfsr;
  logic             solo_active;
  regf_pkg::pe_id_e solo_pe;
  row_t             table_rows [NUM_ROWS];

  regf_read_top UUT (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .alu_req_vld   (req_vld[0]),
    .alu_req_rdy   (req_rdy[0]),
    .alu_req       (req_bus[0]),
    .mem_req_vld   (req_vld[1]),
    .mem_req_rdy   (req_rdy[1]),
    .mem_req       (req_bus[1]),
    .pbs_req_vld   (req_vld[2]),
    .pbs_req_rdy   (req_rdy[2]),
    .pbs_req       (req_bus[2]),
    .wr_en         (wr_en),
    .wr_is_body    (wr_is_body),
    .wr_reg_id     (wr_reg_id),
    .wr_word       (wr_word),
    .wr_data       (wr_data),
    .out_vld       (out_vld),
    .out_data      (out_data),
    .out_pe_id     (out_pe_id),
    .out_last_mask (out_last_mask),
    .out_last_word (out_last_word)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ------------------------------
  // Random data and models
  // ------------------------------
  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_word(output regf_pkg::data_t d);
    for (int b = 0; b < regf_pkg::REGF_DATA_W; b++) begin
      d[b] = lfsr[15];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic regf_pkg::data_t model_word(input regf_pkg::reg_id_t id, input int ofs);
    if (ofs == regf_pkg::REGF_WORD_PER_RAM) begin
      return body_model[id];
    end
    return mask_model[id * regf_pkg::REGF_WORD_PER_RAM + ofs];
  endfunction

  function automatic regf_pkg::regf_rd_req_t make_req(input int id, input int id_1,
                                                      input logic do2, input int start,
                                                      input int nb_m1);
    regf_pkg::regf_rd_req_t r;
    r.reg_id     = regf_pkg::reg_id_t'(id);
    r.reg_id_1   = regf_pkg::reg_id_t'(id_1);
    r.do_2_read  = do2;
    r.start_word = regf_pkg::word_cnt_t'(start);
    r.word_nb_m1 = regf_pkg::word_cnt_t'(nb_m1);
    return r;
  endfunction

  function automatic row_t make_row(input logic [2:0] mask, input int rep,
                                    input regf_pkg::regf_rd_req_t ra,
                                    input regf_pkg::regf_rd_req_t rm,
                                    input regf_pkg::regf_rd_req_t rp,
                                    input int ea, input int em, input int ep);
    row_t r;
    r.pe_mask    = mask;
    r.rep        = 4'(rep);
    r.req[0]     = ra;
    r.req[1]     = rm;
    r.req[2]     = rp;
    r.exp_cnt[0] = 6'(ea);
    r.exp_cnt[1] = 6'(em);
    r.exp_cnt[2] = 6'(ep);
    return r;
  endfunction

  task automatic push_expected(input int pe, input exp_word_t e);
    case (pe)
      0:       exp_alu.push_back(e);
      1:       exp_mem.push_back(e);
      default: exp_pbs.push_back(e);
    endcase
  endtask

  // Each word from reg_id, then from reg_id_1 for a pair
  task automatic add_expected(input int pe, input regf_pkg::regf_rd_req_t r);
    exp_word_t e;
    int        ofs;
    for (int w = 0; w <= r.word_nb_m1; w++) begin
      ofs              = r.start_word + w;
      e.data           = model_word(r.reg_id, ofs);
      e.side.pe_id     = regf_pkg::pe_id_e'(pe);
      e.side.last_mask = (ofs == regf_pkg::REGF_WORD_PER_RAM - 1);
      e.side.last_word = (w == r.word_nb_m1) && !r.do_2_read;
      e.second         = 1'b0;
      push_expected(pe, e);
      if (r.do_2_read) begin
        e.data           = model_word(r.reg_id_1, ofs);
        e.side.last_word = (w == r.word_nb_m1);
        e.second         = 1'b1;
        push_expected(pe, e);
      end
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_data(input regf_pkg::data_t got, input regf_pkg::data_t exp, input int pe);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: element %0d data %h, expected %h", $time, pe, got, exp);
    end
  endtask

  task automatic check_pe(input regf_pkg::pe_id_e got, input regf_pkg::pe_id_e exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: element id %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_side(input regf_pkg::regf_side_t got, input regf_pkg::regf_side_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: side pe %0d mask %b word %b, expected pe %0d mask %b word %b",
               $time, got.pe_id, got.last_mask, got.last_word,
               exp.pe_id, exp.last_mask, exp.last_word);
    end
  endtask

  task automatic check_count(input int got, input int exp, input int pe);
    if (got != exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: element %0d got %0d words, expected %0d", $time, pe, got, exp);
    end
  endtask

  task automatic check_idle();
    if (out_vld !== 1'b0 || req_rdy[0] !== 1'b0 || req_rdy[1] !== 1'b0 || req_rdy[2] !== 1'b0) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: idle out_vld %b rdy %b%b%b, expected all low",
               $time, out_vld, req_rdy[0], req_rdy[1], req_rdy[2]);
    end
  endtask

  // ------------------------------
  // Output monitor
  // ------------------------------
  task automatic check_output();
    exp_word_t            e;
    regf_pkg::regf_side_t got;
    int                   pe;
    logic                 found;
    pe    = int'(out_pe_id);
    found = 1'b1;
    if (solo_active) begin
      check_pe(out_pe_id, solo_pe);
    end
    case (out_pe_id)
      regf_pkg::PE_ALU: begin
        if (exp_alu.size() > 0) e = exp_alu.pop_front();
        else found = 1'b0;
      end
      regf_pkg::PE_MEM: begin
        if (exp_mem.size() > 0) e = exp_mem.pop_front();
        else found = 1'b0;
      end
      regf_pkg::PE_PBS: begin
        if (exp_pbs.size() > 0) e = exp_pbs.pop_front();
        else found = 1'b0;
      end
      default: found = 1'b0;
    endcase
    if (!found) begin
      other_err_cnt++;
      $display("Unexpected read data for element %0d at %0t", pe, $time);
    end else begin
      got.pe_id     = out_pe_id;
      got.last_mask = out_last_mask;
      got.last_word = out_last_word;
      check_data(out_data, e.data, pe);
      check_side(got, e.side);
      // Period limit seen on first reads only
      if (!e.second && out_pe_id != regf_pkg::PE_PBS) begin
        if (cyc - last_first_cyc[pe] < MIN_GAP) begin
          mismatch_cnt++;
          $display("MISMATCH at %0t: element %0d gap of %0d cycles, expected at least %0d",
                   $time, pe, cyc - last_first_cyc[pe], MIN_GAP);
        end
        last_first_cyc[pe] = cyc;
      end
      recv_cnt[pe]++;
    end
  endtask

  always @(negedge clk) begin
    if (s_rst_n === 1'b1 && out_vld === 1'b1) begin
      check_output();
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic load_registers();
    regf_pkg::data_t d;
    for (int id = 0; id < regf_pkg::REGF_REG_NB; id++) begin
      for (int w = 0; w <= regf_pkg::REGF_WORD_PER_RAM; w++) begin
        random_word(d);
        @(posedge clk);
        wr_en      <= 1'b1;
        wr_is_body <= (w == regf_pkg::REGF_WORD_PER_RAM);
        wr_reg_id  <= regf_pkg::reg_id_t'(id);
        wr_word    <= regf_pkg::word_cnt_t'(w);
        wr_data    <= d;
        if (w == regf_pkg::REGF_WORD_PER_RAM) begin
          body_model[id] = d;
        end else begin
          mask_model[id * regf_pkg::REGF_WORD_PER_RAM + w] = d;
        end
        @(negedge clk);
        check_idle();
      end
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // Back-to-back requests, reg ids step by one per request
  task automatic post_requests(input int pe, input regf_pkg::regf_rd_req_t base, input int rep);
    regf_pkg::regf_rd_req_t r;
    int                     waited;
    logic                   accepted;
    @(posedge clk);
    for (int k = 0; k < rep; k++) begin
      r          = base;
      r.reg_id   = regf_pkg::reg_id_t'(base.reg_id + k);
      r.reg_id_1 = regf_pkg::reg_id_t'(base.reg_id_1 + k);
      req_vld[pe] <= 1'b1;
      req_bus[pe] <= r;
      waited   = 0;
      accepted = 1'b0;
      while (!accepted && waited < ACCEPT_LIMIT) begin
        @(negedge clk);
        accepted = req_rdy[pe];
        @(posedge clk);
        waited++;
      end
      if (!accepted) begin
        other_err_cnt++;
        $display("Request %0d of element %0d was never accepted", k, pe);
        req_vld[pe] <= 1'b0;
        return;
      end
      add_expected(pe, r);
    end
    req_vld[pe] <= 1'b0;
  endtask

  initial begin
    row_t row;
    int   pending;
    int   waited;
    logic aborted;
    s_rst_n       = 1'b0;
    wr_en         = 1'b0;
    wr_is_body    = 1'b0;
    wr_reg_id     = '0;
    wr_word       = '0;
    wr_data       = '0;
    lfsr          = 16'd39605;
    mismatch_cnt  = 0;
    other_err_cnt = 0;
    aborted       = 1'b0;
    solo_active   = 1'b0;
    solo_pe       = regf_pkg::PE_ALU;
    for (int p = 0; p < regf_pkg::PE_NB; p++) begin
      req_vld[p]        = 1'b0;
      req_bus[p]        = '0;
      recv_cnt[p]       = 0;
      last_first_cyc[p] = -100;
    end

    // Mask run, run into body, PBS pair, all three, PBS stream, all three repeated
    table_rows[0] = make_row(3'b001, 1, make_req(3, 0, 0, 0, 3), '0, '0, 4, 0, 0);
    table_rows[1] = make_row(3'b010, 1, '0, make_req(7, 0, 0, 2, 2), '0, 0, 3, 0);
    table_rows[2] = make_row(3'b100, 1, '0, '0, make_req(5, 9, 1, 1, 3), 0, 0, 8);
    table_rows[3] = make_row(3'b111, 1, make_req(1, 0, 0, 0, 4), make_req(10, 12, 1, 3, 1),
                             make_req(14, 0, 0, 0, 2), 5, 4, 3);
    table_rows[4] = make_row(3'b100, 4, '0, '0, make_req(2, 0, 0, 0, 0), 0, 0, 4);
    table_rows[5] = make_row(3'b111, 3, make_req(1, 0, 0, 4, 0), make_req(6, 0, 0, 0, 1),
                             make_req(0, 15, 1, 2, 2), 3, 6, 18);

    repeat (4) @(posedge clk);
    s_rst_n <= 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_idle();
    end
    load_registers();

    for (int r = 0; r < NUM_ROWS && !aborted; r++) begin
      row         = table_rows[r];
      solo_active = ($countones(row.pe_mask) == 1);
      solo_pe     = row.pe_mask[0] ? regf_pkg::PE_ALU :
                    row.pe_mask[1] ? regf_pkg::PE_MEM : regf_pkg::PE_PBS;
      fork
        begin
          if (row.pe_mask[0]) post_requests(0, row.req[0], row.rep);
        end
        begin
          if (row.pe_mask[1]) post_requests(1, row.req[1], row.rep);
        end
        begin
          if (row.pe_mask[2]) post_requests(2, row.req[2], row.rep);
        end
      join
      waited  = 0;
      pending = exp_alu.size() + exp_mem.size() + exp_pbs.size();
      while (pending > 0 && waited < DRAIN_LIMIT) begin
        @(posedge clk);
        waited++;
        pending = exp_alu.size() + exp_mem.size() + exp_pbs.size();
      end
      if (pending > 0) begin
        other_err_cnt++;
        $display("Row %0d: %0d expected words never came back", r, pending);
        aborted = 1'b1;
      end
      // Let stray words show up before counting
      repeat (6) @(posedge clk);
      for (int p = 0; p < regf_pkg::PE_NB; p++) begin
        check_count(recv_cnt[p], int'(row.exp_cnt[p]), p);
        recv_cnt[p] = 0;
      end
    end

    $display("Read checks finished: %0d mismatches, %0d other errors",
             mismatch_cnt, other_err_cnt);
    if (mismatch_cnt == 0 && other_err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
logic/regf_pkg.sv
logic/regf_ram_rd_if.sv
logic/regf_req_buffer.sv
logic/regf_read_arbiter.sv
logic/regf_ram_bank.sv
logic/regf_read_top.sv
bench/regf_read_tb.sv
